// ==== rtl/approx_div_pkg.sv ====
`default_nettype none

package approx_div_pkg;

  // dividend width, and the shared width of divisor, quotient and remainder
  localparam int N_W = 16;
  localparam int D_W = 8;

  // clock cycles the combinational array gets before the fsm moves to capture
  localparam int SETTLE_CYCLES = 3;
  localparam int CNT_W = 2;

  // one bit per cell, index row * D_W + column, where row i produces quotient bit i.
  // the approximate cells sit in the low corner of the lowest four rows
  localparam logic [D_W*D_W-1:0] APPROX_MASK = 64'h0000_0000_0103_070f;

  typedef struct packed {
    logic [N_W-1:0] n;
    logic [D_W-1:0] d;
  } div_req_t;

  typedef struct packed {
    logic [D_W-1:0] q;
    logic [D_W-1:0] r;
    logic           dz;
    logic           ovf;
  } div_res_t;

endpackage

`default_nettype wire

// ==== rtl/div_cell.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_cell #(
  parameter bit APPROX = 1'b0
) (
  input  logic x,
  input  logic y,
  input  logic bin,
  input  logic qs,
  output logic r_sub,
  output logic bout
);

  logic diff;

  if (APPROX) begin : g_approx
    // the difference ignores the incoming borrow, and a borrow leaves
    // whenever x is low and either y or bin is set
    assign bout = ~x & (y | bin);
    assign diff = x ^ y;
  end else begin : g_exact
    assign diff = x ^ y ^ bin;
    assign bout = (~x & y) | (~(x ^ y) & bin);
  end

  // a low quotient bit restores the partial remainder bit
  assign r_sub = qs ? diff : x;

endmodule

`default_nettype wire

// ==== rtl/div_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_array (
  input  logic [approx_div_pkg::N_W-1:0] n,
  input  logic [approx_div_pkg::D_W-1:0] d,
  output logic [approx_div_pkg::D_W-1:0] q,
  output logic [approx_div_pkg::D_W-1:0] r
);

  // row D_W-1 is the top row and sees the dividend's high bits first;
  // row 0 is the last and leaves the remainder
  for (genvar i = 0; i < approx_div_pkg::D_W; i++) begin : g_row
    logic qs;

    for (genvar j = 0; j < approx_div_pkg::D_W; j++) begin : g_col
      logic x;
      logic bin;
      logic r_sub;
      logic bout;

      if (j == 0) begin : g_lsb
        // the lowest column of every row brings in the next dividend bit
        assign x   = n[i];
        assign bin = 1'b0;
      end else begin : g_chain
        if (i == approx_div_pkg::D_W - 1) begin : g_top
          assign x = n[approx_div_pkg::D_W - 1 + j];
        end else begin : g_inner
          assign x = g_row[i+1].g_col[j-1].r_sub;
        end
        assign bin = g_col[j-1].bout;
      end

      div_cell #(
        .APPROX (approx_div_pkg::APPROX_MASK[i*approx_div_pkg::D_W + j])
      ) div_cell_inst (
        .x     (x),
        .y     (d[j]),
        .bin   (bin),
        .qs    (qs),
        .r_sub (r_sub),
        .bout  (bout)
      );
    end

    // the bit shifted out above the row counts as a successful subtraction too
    if (i == approx_div_pkg::D_W - 1) begin : g_q_top
      assign qs = n[approx_div_pkg::N_W-1] | ~g_col[approx_div_pkg::D_W-1].bout;
    end else begin : g_q_inner
      assign qs = g_row[i+1].g_col[approx_div_pkg::D_W-1].r_sub |
                  ~g_col[approx_div_pkg::D_W-1].bout;
    end

    assign q[i] = qs;
  end

  for (genvar j = 0; j < approx_div_pkg::D_W; j++) begin : g_rem
    assign r[j] = g_row[0].g_col[j].r_sub;
  end

endmodule

`default_nettype wire

// ==== rtl/div_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_datapath (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     load,
  input  logic                     capture,
  input  approx_div_pkg::div_req_t req,
  output approx_div_pkg::div_res_t res
);

  approx_div_pkg::div_req_t          op_q;
  approx_div_pkg::div_res_t          res_d;
  approx_div_pkg::div_res_t          res_q;
  logic [approx_div_pkg::D_W-1:0]    q_arr;
  logic [approx_div_pkg::D_W-1:0]    r_arr;

  // operands feed the array for the whole settle window
  always_ff @(posedge clk) begin
    if (load) begin
      op_q <= req;
    end
  end

  div_array div_array_inst (
    .n (op_q.n),
    .d (op_q.d),
    .q (q_arr),
    .r (r_arr)
  );

  always_comb begin
    res_d.q  = q_arr;
    res_d.r  = r_arr;
    res_d.dz = (op_q.d == '0);
    // the quotient only fits in D_W bits when the upper byte is below the divisor
    res_d.ovf = (op_q.n[approx_div_pkg::N_W-1 -: approx_div_pkg::D_W] >= op_q.d);
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res_q <= '0;
    end else if (capture) begin
      res_q <= res_d;
    end
  end

  assign res = res_q;

  // operands stay put from the load until the array output is captured
  a_operands_stable : assert property (
    @(posedge clk) disable iff (!arst_n)
    capture |-> (op_q == $past(op_q, approx_div_pkg::SETTLE_CYCLES))
  );

endmodule

`default_nettype wire

// ==== rtl/div_ctrl_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_ctrl_fsm (
  input  logic clk,
  input  logic arst_n,
  input  logic start,
  input  logic expired,
  output logic load,
  output logic timer_start,
  output logic capture,
  output logic busy,
  output logic done
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETTLE,
    ST_DONE
  } state_t;

  state_t state_q;
  state_t state_d;
  logic   done_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (start) begin
          state_d = ST_SETTLE;
        end
      end
      ST_SETTLE: begin
        if (expired) begin
          state_d = ST_DONE;
        end
      end
      ST_DONE: begin
        state_d = ST_IDLE;
      end
      default: begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // done follows the capture cycle, so it lines up with the new result
      done_q  <= (state_q == ST_DONE);
    end
  end

  // a start seen while busy never reaches the data path
  assign load        = (state_q == ST_IDLE) && start;
  assign timer_start = load;
  assign capture     = (state_q == ST_DONE);
  assign busy        = (state_q != ST_IDLE);
  assign done        = done_q;

  a_done_single : assert property (
    @(posedge clk) disable iff (!arst_n)
    done |=> !done
  );

  a_capture_expired : assert property (
    @(posedge clk) disable iff (!arst_n)
    capture |-> expired
  );

  // fixed latency from the accepted start to the capture edge
  a_capture_latency : assert property (
    @(posedge clk) disable iff (!arst_n)
    load |-> ##(approx_div_pkg::SETTLE_CYCLES + 1) capture
  );

endmodule

`default_nettype wire

// ==== rtl/settle_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module settle_timer (
  input  logic clk,
  input  logic arst_n,
  input  logic timer_start,
  output logic expired
);

  typedef logic [approx_div_pkg::CNT_W-1:0] cnt_t;

  cnt_t cnt_q;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt_q <= '0;
    end else if (timer_start) begin
      cnt_q <= cnt_t'(approx_div_pkg::SETTLE_CYCLES - 1);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // stays high while idle as well, the fsm only looks at it in settle
  assign expired = (cnt_q == '0);

  // only a new load may raise the count, so it cannot wrap past zero
  a_no_wrap : assert property (
    @(posedge clk) disable iff (!arst_n)
    !timer_start |=> (cnt_q <= $past(cnt_q))
  );

endmodule

`default_nettype wire

// ==== rtl/approx_div_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module approx_div_top (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     start,
  input  approx_div_pkg::div_req_t req,
  output logic                     busy,
  output logic                     done,
  output approx_div_pkg::div_res_t res
);

  logic load;
  logic capture;
  logic timer_start;
  logic expired;

  div_ctrl_fsm div_ctrl_fsm_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .start       (start),
    .expired     (expired),
    .load        (load),
    .timer_start (timer_start),
    .capture     (capture),
    .busy        (busy),
    .done        (done)
  );

  settle_timer settle_timer_inst (
    .clk         (clk),
    .arst_n      (arst_n),
    .timer_start (timer_start),
    .expired     (expired)
  );

  div_datapath div_datapath_inst (
    .clk     (clk),
    .arst_n  (arst_n),
    .load    (load),
    .capture (capture),
    .req     (req),
    .res     (res)
  );

endmodule

`default_nettype wire

// ==== tests/div_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_checker (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     start,
  input  logic                     busy,
  input  logic                     done,
  input  approx_div_pkg::div_res_t res,
  input  approx_div_pkg::div_res_t exp_res,
  output int                       mismatch_count,
  output int                       fault_count,
  output int                       done_count
);

  // start edge to done edge
  localparam int LATENCY = 4;

  int                       mismatches = 0;
  int                       faults = 0;
  int                       dones = 0;
  int                       cyc = 0;
  int                       accept_cyc = 0;
  logic                     pending = 1'b0;
  logic                     seen_start = 1'b0;
  approx_div_pkg::div_res_t exp_q = '0;

  assign mismatch_count = mismatches;
  assign fault_count    = faults;
  assign done_count     = dones;

  task automatic compare_field(input string name, input logic [7:0] got,
                               input logic [7:0] want);
    if (got !== want) begin
      mismatches++;
      $display("MISMATCH %s: got 0x%02h expected 0x%02h", name, got, want);
    end
  endtask

  always @(posedge clk) begin
    if (arst_n) begin
      cyc++;

      // nothing may happen before the first start
      if (!seen_start) begin
        if (busy || done) begin
          faults++;
          $display("busy or done is high before any start was issued");
        end
        compare_field("res (idle)", {6'b0, res.dz, res.ovf}, 8'h00);
        compare_field("res.q (idle)", res.q, 8'h00);
        compare_field("res.r (idle)", res.r, 8'h00);
      end

      if (done) begin
        dones++;
        if (!pending) begin
          faults++;
          $display("done pulse seen without an accepted start");
        end else begin
          // done rises on the fourth edge and is sampled on the next one
          if (cyc - accept_cyc != LATENCY + 1) begin
            faults++;
            $display("done rose %0d cycles after the start edge instead of %0d",
                     cyc - accept_cyc - 1, LATENCY);
          end
          compare_field("res.q", res.q, exp_q.q);
          compare_field("res.r", res.r, exp_q.r);
          compare_field("res.dz", {7'b0, res.dz}, {7'b0, exp_q.dz});
          compare_field("res.ovf", {7'b0, res.ovf}, {7'b0, exp_q.ovf});
          pending = 1'b0;
        end
        if (busy) begin
          faults++;
          $display("busy is still high in the done cycle");
        end
      end else if (pending) begin
        if (!busy) begin
          faults++;
          $display("busy is low while a division is in flight");
        end
        if (cyc - accept_cyc == LATENCY + 2) begin
          faults++;
          $display("done did not arrive at the expected cycle");
        end
      end

      if (start) begin
        seen_start = 1'b1;
        // a start while busy must be dropped, so the expectation stays
        if (!pending) begin
          pending    = 1'b1;
          accept_cyc = cyc;
          exp_q      = exp_res;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tests/tb_approx_div.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_approx_div;

  localparam int NUM_VEC = 10;
  localparam int TIMEOUT_CYCLES = 50;
  localparam int RESET_CYCLES = 16;

  logic                     clk = 1'b0;
  logic                     arst_n;
  logic                     start;
  approx_div_pkg::div_req_t req;
  logic                     busy;
  logic                     done;
  approx_div_pkg::div_res_t res;
  approx_div_pkg::div_res_t exp_res;

  // n, d, q, r and a flag nibble per line
  logic [43:0]              golden [0:NUM_VEC-1];

  int                       mismatches;
  int                       faults;
  int                       dones;
  int                       timeouts = 0;
  int                       tb_errors = 0;
  logic [31:0]              rng_state = 32'd37;

  always #5 clk = ~clk;

  approx_div_top approx_div_top_inst (
    .clk    (clk),
    .arst_n (arst_n),
    .start  (start),
    .req    (req),
    .busy   (busy),
    .done   (done),
    .res    (res)
  );

  div_checker div_checker_inst (
    .clk            (clk),
    .arst_n         (arst_n),
    .start          (start),
    .busy           (busy),
    .done           (done),
    .res            (res),
    .exp_res        (exp_res),
    .mismatch_count (mismatches),
    .fault_count    (faults),
    .done_count     (dones)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic wait_for_done(input int vec);
    int waited;
    waited = 0;
    while (!done && waited < TIMEOUT_CYCLES) begin
      @(negedge clk);
      waited++;
    end
    if (!done) begin
      timeouts++;
      $display("timeout waiting for done on vector %0d", vec);
    end
  endtask

  task automatic run_vector(input int vec, input logic stray_start);
    int gap;
    rng_state = xorshift32(rng_state);
    gap = int'(rng_state % 32'd4);
    repeat (gap) @(negedge clk);
    @(negedge clk);
    req.n       = golden[vec][43:28];
    req.d       = golden[vec][27:20];
    exp_res.q   = golden[vec][19:12];
    exp_res.r   = golden[vec][11:4];
    exp_res.dz  = golden[vec][1];
    exp_res.ovf = golden[vec][0];
    start       = 1'b1;
    @(negedge clk);
    start = 1'b0;
    if (stray_start) begin
      // a second request during the settle window has to be ignored
      @(negedge clk);
      start = 1'b1;
      req.n = 16'hffff;
      req.d = 8'h01;
      @(negedge clk);
      start = 1'b0;
    end
    wait_for_done(vec);
  endtask

  initial begin
    arst_n  = 1'b0;
    start   = 1'b0;
    req     = '0;
    exp_res = '0;
    $readmemh("tests/approx_div_golden.mem", golden);

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    // idle cycles let the checker see the reset state
    repeat (4) @(negedge clk);

    for (int k = 0; k < NUM_VEC; k++) begin
      run_vector(k, (k == 3) || (k == 6));
    end

    repeat (10) @(negedge clk);
    if (dones != NUM_VEC) begin
      tb_errors++;
      $display("saw %0d done pulses for %0d accepted starts", dones, NUM_VEC);
    end

    $display("errors: mismatches=%0d faults=%0d timeouts=%0d other=%0d",
             mismatches, faults, timeouts, tb_errors);
    if (mismatches + faults + timeouts + tb_errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== approx_div.f ====
rtl/approx_div_pkg.sv
rtl/div_cell.sv
rtl/div_array.sv
rtl/div_datapath.sv
rtl/div_ctrl_fsm.sv
rtl/settle_timer.sv
rtl/approx_div_top.sv
tests/div_checker.sv
tests/tb_approx_div.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the approximate divider testbench with Verilator and runs it

set -u

cd "$(dirname "$0")" || exit 1

LOG_FILE="sim.log"
PASS_TEXT="Test completed successfully"

verilator --binary --timing --assert \
  -f approx_div.f \
  --top-module tb_approx_div \
  -o tb_approx_div
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/tb_approx_div > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"
if [ "$run_status" -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "$PASS_TEXT" "$LOG_FILE"; then
  exit 0
fi
exit 1

// ==== tests/approx_div_golden.mem ====
// columns: n (4 hex) d (2 hex) q (2 hex) r (2 hex) flags (1 hex)
// flags bit 1 is dz, bit 0 is ovf; q and r come from the approximate array
// exact result, divide 5 by 1
00050105000
// exact result, divide 255 by 16
00ff100f0f0
// approximate cells give q 0f r 09 where exact division gives 0e r 02
0064070f090
// approximate cells give q 03 r 01 where exact division gives 01 r 01
00080703010
// zero divisor passes the low dividend byte through as the remainder
123400ff343
abcd00ffcd3
// just below the overflow bound for d 10
0fff10ff0f0
// at the overflow bound for d 10
100010ff101
// just below the overflow bound for d 80
7fff80ff7f0
// at the overflow bound for d 80
800080ff801
